// File: hdl/mips_ctrl_pkg.sv
`default_nettype none

package mips_ctrl_pkg;

    // Memory control bus {sb, sh, lb, lh, unsigned, bneq, branch, memread, memwrite}
    localparam int ctrl_mem_w  = 9;

    // Write-back pair {regwrite, memtoreg}
    localparam int ctrl_wb_w   = 2;

    localparam int cm_sb       = 8;
    localparam int cm_sh       = 7;
    localparam int cm_lb       = 6;
    localparam int cm_lh       = 5;
    localparam int cm_unsigned = 4;
    localparam int cm_bneq     = 3;
    localparam int cm_branch   = 2;
    localparam int cm_memread  = 1;
    localparam int cm_memwrite = 0;

    // Store size as seen by the data memory
    typedef enum logic [1:0] {
        size_word = 2'b00,
        size_half = 2'b01,
        size_byte = 2'b10
    } store_size_e;

endpackage

`default_nettype wire

// File: hdl/mips_mem_pkg.sv
`default_nettype none

package mips_mem_pkg;

    localparam int data_w         = 32;
    localparam int reg_addr_w     = 5;

    // Data memory size in words
    localparam int mem_depth      = 256;

    // Byte address split into word index and byte offset
    localparam int word_addr_w    = 8;
    localparam int byte_off_w     = 2;

    localparam int byte_w         = 8;
    localparam int half_w         = 16;
    localparam int bytes_per_word = data_w / byte_w;

    // One data word seen as a word, two halves or four bytes
    // Lane 0 is the least significant in each view
    typedef union packed {
        logic [data_w-1:0]                     word;
        logic [1:0][half_w-1:0]                halves;
        logic [bytes_per_word-1:0][byte_w-1:0] bytes;
    } data_word_u;

endpackage

`default_nettype wire

// File: hdl/mem_stage_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mem_stage_if
    import mips_ctrl_pkg::*;
    import mips_mem_pkg::*;
();

    logic                  valid;
    logic [data_w-1:0]     addr;
    logic [data_w-1:0]     wdata;
    logic                  mem_write;
    logic                  mem_read;
    store_size_e           store_size;
    logic                  load_byte;
    logic                  load_half;
    logic                  load_unsigned;
    logic [reg_addr_w-1:0] wreg;
    logic [ctrl_wb_w-1:0]  ctrl_wb;

    modport prod (
        output valid, addr, wdata, mem_write, mem_read, store_size,
               load_byte, load_half, load_unsigned, wreg, ctrl_wb
    );

    modport mem (
        input valid, addr, wdata, mem_write, mem_read, store_size
    );

    modport cons (
        input valid, addr, load_byte, load_half, load_unsigned, wreg, ctrl_wb
    );

endinterface

`default_nettype wire

// File: hdl/ex_mem_reg.sv
`timescale 1ns/10ps
`default_nettype none

module ex_mem_reg
    import mips_ctrl_pkg::*, mips_mem_pkg::*;
(
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  wire                    i_valid,
    input  wire [data_w-1:0]       i_pc_branch,
    input  wire [data_w-1:0]       i_alu_result,
    input  wire [data_w-1:0]       i_write_data,
    input  wire [reg_addr_w-1:0]   i_write_register,
    input  wire                    i_alu_zero,
    input  wire [ctrl_wb_w-1:0]    i_ctrl_wb,
    input  wire [ctrl_mem_w-1:0]   i_ctrl_mem,
    mem_stage_if.prod              o_stage,
    output logic                   o_pc_src,
    output logic [data_w-1:0]      o_pc_branch
);

    logic        branch_taken;
    store_size_e size_d;

    // beq on zero, bne on non-zero
    assign branch_taken = i_ctrl_mem[cm_branch] &
                          (i_ctrl_mem[cm_bneq] ? ~i_alu_zero : i_alu_zero);

    always_comb begin
        if (i_ctrl_mem[cm_sb]) begin
            size_d = size_byte;
        end else if (i_ctrl_mem[cm_sh]) begin
            size_d = size_half;
        end else begin
            size_d = size_word;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_stage.valid         <= 1'b0;
            o_stage.addr          <= '0;
            o_stage.wdata         <= '0;
            o_stage.mem_write     <= 1'b0;
            o_stage.mem_read      <= 1'b0;
            o_stage.store_size    <= size_word;
            o_stage.load_byte     <= 1'b0;
            o_stage.load_half     <= 1'b0;
            o_stage.load_unsigned <= 1'b0;
            o_stage.wreg          <= '0;
            o_stage.ctrl_wb       <= '0;
            o_pc_src              <= 1'b0;
            o_pc_branch           <= '0;
        end else begin
            o_stage.valid <= i_valid;
            // Qualified so a taken branch pulses once
            o_pc_src      <= i_valid & branch_taken;
            if (i_valid) begin
                o_stage.addr          <= i_alu_result;
                o_stage.wdata         <= i_write_data;
                o_stage.mem_write     <= i_ctrl_mem[cm_memwrite];
                o_stage.mem_read      <= i_ctrl_mem[cm_memread];
                o_stage.store_size    <= size_d;
                o_stage.load_byte     <= i_ctrl_mem[cm_lb];
                o_stage.load_half     <= i_ctrl_mem[cm_lh];
                o_stage.load_unsigned <= i_ctrl_mem[cm_unsigned];
                o_stage.wreg          <= i_write_register;
                o_stage.ctrl_wb       <= i_ctrl_wb;
                o_pc_branch           <= i_pc_branch;
            end
        end
    end

    sb_sh_exclusive_a : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_valid |-> !(i_ctrl_mem[cm_sb] && i_ctrl_mem[cm_sh]))
        else $error("ex_mem_reg: store byte and store half set together");

endmodule

`default_nettype wire

// File: hdl/data_mem.sv
`timescale 1ns/10ps
`default_nettype none

module data_mem
    import mips_ctrl_pkg::*, mips_mem_pkg::*;
#(
    parameter int mem_depth_p = mem_depth
)(
    input  wire                i_clk,
    mem_stage_if.mem           i_stage,
    output logic [data_w-1:0]  o_rdata
);

    data_word_u                mem_q [mem_depth_p];
    data_word_u                wdata_u;
    data_word_u                wr_word;
    logic [bytes_per_word-1:0] byte_en;
    logic [word_addr_w-1:0]    word_idx;
    logic [byte_off_w-1:0]     byte_off;

    assign word_idx = i_stage.addr[byte_off_w +: word_addr_w];
    assign byte_off = i_stage.addr[byte_off_w-1:0];
    assign wdata_u  = data_word_u'(i_stage.wdata);

    // Move the low byte or half of the store data into its lane
    always_comb begin
        wr_word.word = '0;
        byte_en      = '0;
        case (i_stage.store_size)
            size_byte: begin
                wr_word.bytes[byte_off] = wdata_u.bytes[0];
                byte_en[byte_off]       = 1'b1;
            end
            size_half: begin
                wr_word.halves[byte_off[1]] = wdata_u.halves[0];
                byte_en[2*byte_off[1] +: 2] = 2'b11;
            end
            default: begin
                wr_word.word = wdata_u.word;
                byte_en      = '1;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_stage.valid && i_stage.mem_write) begin
            for (int i = 0; i < bytes_per_word; i++) begin
                if (byte_en[i]) begin
                    mem_q[word_idx].bytes[i] <= wr_word.bytes[i];
                end
            end
        end
        // Read port holds its word until the next load
        if (i_stage.valid && i_stage.mem_read) begin
            o_rdata <= mem_q[word_idx].word;
        end
    end

    rd_wr_exclusive_a : assert property (@(posedge i_clk)
        i_stage.valid |-> !(i_stage.mem_read && i_stage.mem_write))
        else $error("data_mem: read and write on the same strobe");

    store_in_range_a : assert property (@(posedge i_clk)
        (i_stage.valid && i_stage.mem_write) |->
            (i_stage.addr[data_w-1:byte_off_w] < mem_depth_p))
        else $error("data_mem: store address beyond memory depth");

endmodule

`default_nettype wire

// File: hdl/mem_wb_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_wb_stage
    import mips_ctrl_pkg::*, mips_mem_pkg::*;
(
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    mem_stage_if.cons              i_stage,
    input  wire [data_w-1:0]       i_rdata,
    output logic                   o_wb_valid,
    output logic [data_w-1:0]      o_read_data,
    output logic [reg_addr_w-1:0]  o_write_register,
    output logic [ctrl_wb_w-1:0]   o_ctrl_wb
);

    logic                  valid_q;
    logic [byte_off_w-1:0] off_q;
    logic                  load_byte_q;
    logic                  load_half_q;
    logic                  load_unsigned_q;
    logic [reg_addr_w-1:0] wreg_q;
    logic [ctrl_wb_w-1:0]  ctrl_wb_q;
    data_word_u            rd_word;
    logic [byte_w-1:0]     lane_byte;
    logic [half_w-1:0]     lane_half;
    logic                  byte_fill;
    logic                  half_fill;
    logic [data_w-1:0]     load_data;

    // Load controls line up with the memory read at E1
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q         <= 1'b0;
            off_q           <= '0;
            load_byte_q     <= 1'b0;
            load_half_q     <= 1'b0;
            load_unsigned_q <= 1'b0;
            wreg_q          <= '0;
            ctrl_wb_q       <= '0;
        end else begin
            valid_q <= i_stage.valid;
            if (i_stage.valid) begin
                off_q           <= i_stage.addr[byte_off_w-1:0];
                load_byte_q     <= i_stage.load_byte;
                load_half_q     <= i_stage.load_half;
                load_unsigned_q <= i_stage.load_unsigned;
                wreg_q          <= i_stage.wreg;
                ctrl_wb_q       <= i_stage.ctrl_wb;
            end
        end
    end

    assign rd_word   = data_word_u'(i_rdata);
    assign lane_byte = rd_word.bytes[off_q];
    assign lane_half = rd_word.halves[off_q[1]];
    assign byte_fill = ~load_unsigned_q & lane_byte[byte_w-1];
    assign half_fill = ~load_unsigned_q & lane_half[half_w-1];

    always_comb begin
        if (load_byte_q) begin
            load_data = {{(data_w-byte_w){byte_fill}}, lane_byte};
        end else if (load_half_q) begin
            load_data = {{(data_w-half_w){half_fill}}, lane_half};
        end else begin
            load_data = rd_word.word;  // word load, or don't-care for non-loads
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_valid       <= 1'b0;
            o_read_data      <= '0;
            o_write_register <= '0;
            o_ctrl_wb        <= '0;
        end else begin
            o_wb_valid <= valid_q;
            if (valid_q) begin
                o_read_data      <= load_data;
                o_write_register <= wreg_q;
                o_ctrl_wb        <= ctrl_wb_q;
            end
        end
    end

    lb_lh_exclusive_a : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_stage.valid |-> !(i_stage.load_byte && i_stage.load_half))
        else $error("mem_wb_stage: load byte and load half set together");

endmodule

`default_nettype wire

// File: hdl/mem_access_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_access_top
    import mips_ctrl_pkg::*, mips_mem_pkg::*;
(
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  wire                    i_valid,
    input  wire [data_w-1:0]       i_pc_branch,
    input  wire [data_w-1:0]       i_alu_result,
    input  wire [data_w-1:0]       i_write_data,
    input  wire [reg_addr_w-1:0]   i_write_register,
    input  wire                    i_alu_zero,
    input  wire [ctrl_wb_w-1:0]    i_ctrl_wb,
    input  wire [ctrl_mem_w-1:0]   i_ctrl_mem,
    output logic                   o_pc_src,
    output logic [data_w-1:0]      o_pc_branch,
    output logic [data_w-1:0]      o_address,
    output logic                   o_wb_valid,
    output logic [data_w-1:0]      o_read_data,
    output logic [reg_addr_w-1:0]  o_write_register,
    output logic [ctrl_wb_w-1:0]   o_ctrl_wb
);

    logic [data_w-1:0] mem_rdata;

    mem_stage_if stage_if ();

    // Execute/memory pipeline register and branch decision
    ex_mem_reg u_ex_mem_reg (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_valid          (i_valid),
        .i_pc_branch      (i_pc_branch),
        .i_alu_result     (i_alu_result),
        .i_write_data     (i_write_data),
        .i_write_register (i_write_register),
        .i_alu_zero       (i_alu_zero),
        .i_ctrl_wb        (i_ctrl_wb),
        .i_ctrl_mem       (i_ctrl_mem),
        .o_stage          (stage_if.prod),
        .o_pc_src         (o_pc_src),
        .o_pc_branch      (o_pc_branch)
    );

    data_mem #(
        .mem_depth_p (mem_depth)
    ) u_data_mem (
        .i_clk   (i_clk),
        .i_stage (stage_if.mem),
        .o_rdata (mem_rdata)
    );

    // Load extension and write-back register
    mem_wb_stage u_mem_wb_stage (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_stage          (stage_if.cons),
        .i_rdata          (mem_rdata),
        .o_wb_valid       (o_wb_valid),
        .o_read_data      (o_read_data),
        .o_write_register (o_write_register),
        .o_ctrl_wb        (o_ctrl_wb)
    );

    assign o_address = stage_if.addr;

endmodule

`default_nettype wire

// File: verif/mem_access_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_access_tb
    import mips_ctrl_pkg::*, mips_mem_pkg::*;
();

    localparam int max_tests  = 64;
    localparam int wb_timeout = 20;

    logic                  i_clk;
    logic                  i_rst_n;
    logic                  i_valid;
    logic [data_w-1:0]     i_pc_branch;
    logic [data_w-1:0]     i_alu_result;
    logic [data_w-1:0]     i_write_data;
    logic [reg_addr_w-1:0] i_write_register;
    logic                  i_alu_zero;
    logic [ctrl_wb_w-1:0]  i_ctrl_wb;
    logic [ctrl_mem_w-1:0] i_ctrl_mem;
    logic                  o_pc_src;
    logic [data_w-1:0]     o_pc_branch;
    logic [data_w-1:0]     o_address;
    logic                  o_wb_valid;
    logic [data_w-1:0]     o_read_data;
    logic [reg_addr_w-1:0] o_write_register;
    logic [ctrl_wb_w-1:0]  o_ctrl_wb;

    // Test table as read from the file
    string                 t_name      [max_tests];
    logic [ctrl_mem_w-1:0] t_ctrl_mem  [max_tests];
    logic [ctrl_wb_w-1:0]  t_ctrl_wb   [max_tests];
    logic [data_w-1:0]     t_pc        [max_tests];
    logic [data_w-1:0]     t_addr      [max_tests];
    logic [data_w-1:0]     t_wdata     [max_tests];
    logic                  t_zero      [max_tests];
    logic [reg_addr_w-1:0] t_reg       [max_tests];
    logic                  t_exp_pc    [max_tests];
    logic [data_w-1:0]     t_exp_rdata [max_tests];
    bit                    t_bad       [max_tests];

    int          n_tests;
    int          pass_count;
    int          fail_count;
    int          stray_count;
    int          wb_pulses;
    bit          aborted;
    int          br_q [$];
    int          wb_q [$];
    bit          br_pending;
    int          br_idx;
    logic [23:0] lfsr;

    mem_access_top dut_i (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_valid          (i_valid),
        .i_pc_branch      (i_pc_branch),
        .i_alu_result     (i_alu_result),
        .i_write_data     (i_write_data),
        .i_write_register (i_write_register),
        .i_alu_zero       (i_alu_zero),
        .i_ctrl_wb        (i_ctrl_wb),
        .i_ctrl_mem       (i_ctrl_mem),
        .o_pc_src         (o_pc_src),
        .o_pc_branch      (o_pc_branch),
        .o_address        (o_address),
        .o_wb_valid       (o_wb_valid),
        .o_read_data      (o_read_data),
        .o_write_register (o_write_register),
        .o_ctrl_wb        (o_ctrl_wb)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // Taps 24, 23, 22, 17
    function automatic logic [23:0] lfsr_next(input logic [23:0] state);
        logic feedback;
        feedback = state[23] ^ state[22] ^ state[21] ^ state[16];
        return {state[22:0], feedback};
    endfunction

    task automatic load_tests();
        int                    fd;
        int                    fields;
        string                 line;
        string                 name;
        logic [ctrl_mem_w-1:0] cm;
        logic [ctrl_wb_w-1:0]  wb;
        logic [data_w-1:0]     pc;
        logic [data_w-1:0]     addr;
        logic [data_w-1:0]     wdata;
        logic                  zero;
        logic [reg_addr_w-1:0] rg;
        logic                  epc;
        logic [data_w-1:0]     erd;
        fd = $fopen("verif/mem_access_tests.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open verif/mem_access_tests.txt");
            aborted = 1'b1;
        end else begin
            while (!$feof(fd) && n_tests < max_tests) begin
                line = "";
                void'($fgets(line, fd));
                // Skip blank lines and comments
                if (line.len() > 1 && line[0] != "#") begin
                    fields = $sscanf(line, "%s %h %h %h %h %h %h %d %h %h",
                                     name, cm, wb, pc, addr, wdata, zero, rg, epc, erd);
                    if (fields == 10) begin
                        t_name[n_tests]      = name;
                        t_ctrl_mem[n_tests]  = cm;
                        t_ctrl_wb[n_tests]   = wb;
                        t_pc[n_tests]        = pc;
                        t_addr[n_tests]      = addr;
                        t_wdata[n_tests]     = wdata;
                        t_zero[n_tests]      = zero;
                        t_reg[n_tests]       = rg;
                        t_exp_pc[n_tests]    = epc;
                        t_exp_rdata[n_tests] = erd;
                        t_bad[n_tests]       = 1'b0;
                        n_tests++;
                    end else begin
                        $display("ERROR: malformed test line: %0s", line);
                        aborted = 1'b1;
                    end
                end
            end
            $fclose(fd);
            if (n_tests == 0) begin
                $display("ERROR: the test file holds no tests");
                aborted = 1'b1;
            end
        end
    endtask

    task automatic drive_tests();
        int         gap;
        logic [1:0] gap_bits;
        for (int i = 0; i < n_tests; i++) begin
            // One LFSR step per gap bit
            lfsr        = lfsr_next(lfsr);
            gap_bits[0] = lfsr[0];
            lfsr        = lfsr_next(lfsr);
            gap_bits[1] = lfsr[0];
            gap         = int'(gap_bits);
            if (t_name[i].substr(0, 3) == "b2b_") begin
                gap = 0;
            end
            repeat (gap) begin
                @(posedge i_clk);
                i_valid <= 1'b0;
            end
            @(posedge i_clk);
            i_valid          <= 1'b1;
            i_ctrl_mem       <= t_ctrl_mem[i];
            i_ctrl_wb        <= t_ctrl_wb[i];
            i_pc_branch      <= t_pc[i];
            i_alu_result     <= t_addr[i];
            i_write_data     <= t_wdata[i];
            i_alu_zero       <= t_zero[i];
            i_write_register <= t_reg[i];
            br_q.push_back(i);
            wb_q.push_back(i);
        end
        @(posedge i_clk);
        i_valid <= 1'b0;
    endtask

    // Branch outputs belong to the strobe seen one falling edge earlier
    task automatic check_branch(input int idx);
        if (o_pc_src !== t_exp_pc[idx]) begin
            $display("MISMATCH %0s o_pc_src: expected %0h, actual %0h",
                     t_name[idx], t_exp_pc[idx], o_pc_src);
            t_bad[idx] = 1'b1;
        end
        if (o_pc_branch !== t_pc[idx]) begin
            $display("MISMATCH %0s o_pc_branch: expected %h, actual %h",
                     t_name[idx], t_pc[idx], o_pc_branch);
            t_bad[idx] = 1'b1;
        end
        if (o_address !== t_addr[idx]) begin
            $display("MISMATCH %0s o_address: expected %h, actual %h",
                     t_name[idx], t_addr[idx], o_address);
            t_bad[idx] = 1'b1;
        end
    endtask

    always @(negedge i_clk) begin
        if (br_pending) begin
            check_branch(br_idx);
        end else if (i_rst_n && o_pc_src !== 1'b0) begin
            $display("ERROR: o_pc_src high with no operation behind it");
            stray_count++;
        end
        br_pending = 1'b0;
        if (i_rst_n && i_valid && br_q.size() > 0) begin
            br_idx     = br_q.pop_front();
            br_pending = 1'b1;
        end
        // Every write-back strobe is counted against the operations issued
        if (i_rst_n && o_wb_valid === 1'b1) begin
            wb_pulses++;
        end
    end

    task automatic collect_results();
        int idx;
        int waited;
        bit bad;
        for (int n = 0; n < n_tests && !aborted; n++) begin
            waited = 0;
            while (wb_q.size() == 0 && waited < wb_timeout) begin
                @(negedge i_clk);
                waited++;
            end
            if (wb_q.size() == 0) begin
                $display("ERROR: no operation was issued within %0d cycles", wb_timeout);
                aborted = 1'b1;
            end else begin
                idx    = wb_q.pop_front();
                waited = 0;
                do begin
                    @(negedge i_clk);
                    waited++;
                end while (o_wb_valid !== 1'b1 && waited < wb_timeout);
                if (o_wb_valid !== 1'b1) begin
                    $display("ERROR: test %0s got no write-back result within %0d cycles",
                             t_name[idx], wb_timeout);
                    aborted = 1'b1;
                end else begin
                    bad = t_bad[idx];
                    if (o_write_register !== t_reg[idx]) begin
                        $display("MISMATCH %0s o_write_register: expected %0d, actual %0d",
                                 t_name[idx], t_reg[idx], o_write_register);
                        bad = 1'b1;
                    end
                    if (o_ctrl_wb !== t_ctrl_wb[idx]) begin
                        $display("MISMATCH %0s o_ctrl_wb: expected %0h, actual %0h",
                                 t_name[idx], t_ctrl_wb[idx], o_ctrl_wb);
                        bad = 1'b1;
                    end
                    // Read data means something only for loads
                    if (t_ctrl_mem[idx][cm_memread] && o_read_data !== t_exp_rdata[idx]) begin
                        $display("MISMATCH %0s o_read_data: expected %h, actual %h",
                                 t_name[idx], t_exp_rdata[idx], o_read_data);
                        bad = 1'b1;
                    end
                    if (bad) begin
                        fail_count++;
                        $display("test %0s: failed", t_name[idx]);
                    end else begin
                        pass_count++;
                        $display("test %0s: passed", t_name[idx]);
                    end
                end
            end
        end
    endtask

    initial begin
        i_rst_n          = 1'b0;
        i_valid          = 1'b0;
        i_pc_branch      = '0;
        i_alu_result     = '0;
        i_write_data     = '0;
        i_write_register = '0;
        i_alu_zero       = 1'b0;
        i_ctrl_wb        = '0;
        i_ctrl_mem       = '0;
        lfsr             = 24'd82571;
        load_tests();
        repeat (16) @(posedge i_clk);
        i_rst_n <= 1'b1;
        repeat (2) @(posedge i_clk);
        if (!aborted) begin
            fork
                drive_tests();
                collect_results();
            join
        end
        repeat (4) @(posedge i_clk);
        if (!aborted && wb_pulses != n_tests) begin
            $display("ERROR: %0d write-back strobes seen for %0d operations",
                     wb_pulses, n_tests);
        end
        $display("Tests: %0d run, %0d passed, %0d failed, %0d stray branch pulses",
                 n_tests, pass_count, fail_count, stray_count);
        if (!aborted && fail_count == 0 && stray_count == 0 && pass_count == n_tests &&
            wb_pulses == n_tests) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mem_access_top.f
hdl/mips_ctrl_pkg.sv
hdl/mips_mem_pkg.sv
hdl/mem_stage_if.sv
hdl/ex_mem_reg.sv
hdl/data_mem.sv
hdl/mem_wb_stage.sv
hdl/mem_access_top.sv
verif/mem_access_tb.sv

// File: Makefile
TOP      = mem_access_tb
FILELIST = mem_access_top.f

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f $(FILELIST) -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only -Wall --top-module mem_access_top \
		hdl/mips_ctrl_pkg.sv hdl/mips_mem_pkg.sv hdl/mem_stage_if.sv \
		hdl/ex_mem_reg.sv hdl/data_mem.sv hdl/mem_wb_stage.sv \
		hdl/mem_access_top.sv

clean:
	rm -rf obj_dir sim.log

// File: verif/mem_access_tests.txt
# name ctrl_mem(hex) ctrl_wb(hex) pc_branch addr wdata zero reg(dec) exp_pc_src exp_rdata
# exp_rdata is checked for loads only; names starting with b2b_ follow with no idle cycle
sw_word     001 0 00000000 00000010 deadbeef 0 1  0 00000000
lw_word     002 3 00000000 00000010 00000000 0 8  0 deadbeef
sw_base     001 0 00000000 00000020 11223344 0 2  0 00000000
sb_lane0    101 0 00000000 00000020 000000aa 0 3  0 00000000
lw_lane0    002 3 00000000 00000020 00000000 0 9  0 112233aa
sb_lane1    101 0 00000000 00000021 ffffffbb 0 4  0 00000000
sb_lane2    101 0 00000000 00000022 000000cc 0 5  0 00000000
sb_lane3    101 0 00000000 00000023 000000dd 0 6  0 00000000
lw_merged   002 3 00000000 00000020 00000000 0 10 0 ddccbbaa
lb_lane0    042 3 00000000 00000020 00000000 0 11 0 ffffffaa
lb_lane3    042 3 00000000 00000023 00000000 0 12 0 ffffffdd
lh_upper    022 3 00000000 00000022 00000000 0 13 0 ffffddcc
lh_lower    022 3 00000000 00000020 00000000 0 14 0 ffffbbaa
sw_signs    001 0 00000000 00000030 80f07f01 0 7  0 00000000
sh_upper    081 0 00000000 00000032 abcd1234 0 7  0 00000000
lb_positive 042 3 00000000 00000031 00000000 0 15 0 0000007f
lh_positive 022 3 00000000 00000032 00000000 0 16 0 00001234
lbu_lane1   052 3 00000000 00000021 00000000 0 17 0 000000bb
lhu_upper   032 3 00000000 00000022 00000000 0 18 0 0000ddcc
lhu_lower   032 3 00000000 00000020 00000000 0 19 0 0000bbaa
beq_taken   004 0 00400100 00000000 00000000 1 0  1 00000000
beq_not     004 0 00400200 00000004 00000000 0 0  0 00000000
bne_taken   00c 0 00400300 00000008 00000000 0 0  1 00000000
bne_not     00c 0 00400400 0000000c 00000000 1 0  0 00000000
lw_zero_set 002 3 00000000 00000010 00000000 1 20 0 deadbeef
b2b_sw      001 0 00000000 00000040 cafef00d 0 21 0 00000000
b2b_lw      002 3 00000000 00000040 00000000 0 22 0 cafef00d
b2b_sb      101 0 00000000 00000041 00000055 0 23 0 00000000
b2b_lbu     052 3 00000000 00000041 00000000 0 24 0 00000055
b2b_lw2     002 3 00000000 00000040 00000000 0 25 0 cafe550d
